//--- Bender.yml
package:
  name: rvv_backend

sources:
  - rvv_pkg.sv
  - rvv_fifo.sv
  - rvv_decode.sv
  - rvv_dispatch.sv
  - rvv_alu.sv
  - rvv_rob.sv
  - rvv_vrf.sv
  - rvv_backend.sv
  - target: test
    files:
      - tb_rvv_backend.sv

//--- all.f
rvv_pkg.sv
rvv_fifo.sv
rvv_decode.sv
rvv_dispatch.sv
rvv_alu.sv
rvv_rob.sv
rvv_vrf.sv
rvv_backend.sv
tb_rvv_backend.sv

//--- rvv_alu.sv
`default_nettype none

module rvv_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  rvv_pkg::alu_uop_t rs_data,
    input  logic              rs_empty,
    output logic              rs_pop,
    output logic              wb_valid,
    output rvv_pkg::rob_wb_t  wb
);

    import rvv_pkg::*;

    logic [vlen-1:0] opa;
    logic [vlen-1:0] res;

    function automatic logic [31:0] elem_op(alu_op_e op, logic [31:0] b, logic [31:0] a);
        case (op)
            op_add:  return b + a;
            op_sub:  return b - a;
            op_and:  return b & a;
            op_or:   return b | a;
            op_xor:  return b ^ a;
            default: return a;
        endcase
    endfunction

    assign rs_pop = !rs_empty;

    // Scalar repeated at element width, merged with the zeroed vs1
    always_comb begin
        case (rs_data.sew)
            sew_8:   opa = {(vlen/8){rs_data.scalar[7:0]}};
            sew_16:  opa = {(vlen/16){rs_data.scalar[15:0]}};
            default: opa = {(vlen/32){rs_data.scalar}};
        endcase
        opa = opa | rs_data.vs1_data;
    end

    // vs2 is the minuend, upper bits of each result are dropped
    always_comb begin
        logic [31:0] tmp;
        res = '0;
        case (rs_data.sew)
            sew_8: begin
                for (int i = 0; i < vlen / 8; i++) begin
                    tmp = elem_op(rs_data.op, 32'(rs_data.vs2_data[i*8 +: 8]),
                                  32'(opa[i*8 +: 8]));
                    res[i*8 +: 8] = tmp[7:0];
                end
            end
            sew_16: begin
                for (int i = 0; i < vlen / 16; i++) begin
                    tmp = elem_op(rs_data.op, 32'(rs_data.vs2_data[i*16 +: 16]),
                                  32'(opa[i*16 +: 16]));
                    res[i*16 +: 16] = tmp[15:0];
                end
            end
            default: begin
                for (int i = 0; i < vlen / 32; i++) begin
                    res[i*32 +: 32] = elem_op(rs_data.op, rs_data.vs2_data[i*32 +: 32],
                                              opa[i*32 +: 32]);
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb       <= '0;
        end else begin
            wb_valid <= rs_pop;
            if (rs_pop) begin
                wb.rob_idx <= rs_data.rob_idx;
                wb.data    <= res;
            end
        end
    end

endmodule

`default_nettype wire

//--- rvv_backend.sv
`default_nettype none

module rvv_backend (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [rvv_pkg::issue_lanes-1:0]              inst_valid,
    input  rvv_pkg::rvv_cmd_t [rvv_pkg::issue_lanes-1:0] inst,
    output logic [rvv_pkg::issue_lanes-1:0]              inst_ready,
    output logic                                         rt_valid,
    output rvv_pkg::retire_t                             rt,
    input  logic                                         rt_ready
);

    import rvv_pkg::*;

    // Command queue to decode
    rvv_cmd_t cq_data;
    logic     cq_empty;
    logic     cq_pop;

    // Decode to dispatch
    logic     uop_valid;
    rvv_uop_t uop;
    logic     uop_ready;

    // Dispatch to reorder buffer and station
    logic       alloc_valid;
    rob_alloc_t alloc;
    logic       alloc_ready;
    rob_idx_t   alloc_idx;
    logic       rs_push;
    alu_uop_t   rs_data;
    logic       rs_ready;

    // Station to ALU, ALU to reorder buffer
    alu_uop_t rs_head;
    logic     rs_empty;
    logic     rs_pop;
    logic     wb_valid;
    rob_wb_t  wb;

    // Register file traffic
    logic [num_vreg-1:0]      pending_vregs;
    vreg_idx_t [1:0]          rd_idx;
    logic [1:0][vlen-1:0]     rd_data;
    logic                     vrf_wr_valid;
    vrf_wr_t                  vrf_wr;

    rvv_fifo #(
        .T        (rvv_cmd_t),
        .depth    (cq_depth),
        .num_push (issue_lanes)
    ) u_cmd_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (inst_valid & inst_ready),
        .push_data (inst),
        .pop       (cq_pop),
        .pop_data  (cq_data),
        .empty     (cq_empty),
        .free_ok   (inst_ready)
    );

    rvv_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .cq_data   (cq_data),
        .cq_empty  (cq_empty),
        .cq_pop    (cq_pop),
        .uop_valid (uop_valid),
        .uop       (uop),
        .uop_ready (uop_ready)
    );

    rvv_dispatch u_dispatch (
        .uop_valid     (uop_valid),
        .uop           (uop),
        .uop_ready     (uop_ready),
        .pending_vregs (pending_vregs),
        .rd_idx        (rd_idx),
        .rd_data       (rd_data),
        .alloc_valid   (alloc_valid),
        .alloc         (alloc),
        .alloc_ready   (alloc_ready),
        .alloc_idx     (alloc_idx),
        .rs_push       (rs_push),
        .rs_data       (rs_data),
        .rs_ready      (rs_ready)
    );

    rvv_fifo #(
        .T        (alu_uop_t),
        .depth    (rs_depth),
        .num_push (1)
    ) u_alu_rs (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rs_push),
        .push_data (rs_data),
        .pop       (rs_pop),
        .pop_data  (rs_head),
        .empty     (rs_empty),
        .free_ok   (rs_ready)
    );

    rvv_alu u_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs_data  (rs_head),
        .rs_empty (rs_empty),
        .rs_pop   (rs_pop),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    rvv_rob u_rob (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_valid   (alloc_valid),
        .alloc         (alloc),
        .alloc_ready   (alloc_ready),
        .alloc_idx     (alloc_idx),
        .wb_valid      (wb_valid),
        .wb            (wb),
        .pending_vregs (pending_vregs),
        .rt_valid      (rt_valid),
        .rt            (rt),
        .rt_ready      (rt_ready),
        .vrf_wr_valid  (vrf_wr_valid),
        .vrf_wr        (vrf_wr)
    );

    rvv_vrf u_vrf (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data),
        .wr_valid (vrf_wr_valid),
        .wr       (vrf_wr)
    );

endmodule

`default_nettype wire

//--- rvv_decode.sv
`default_nettype none

module rvv_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  rvv_pkg::rvv_cmd_t cq_data,
    input  logic              cq_empty,
    output logic              cq_pop,
    output logic              uop_valid,
    output rvv_pkg::rvv_uop_t uop,
    input  logic              uop_ready
);

    import rvv_pkg::*;

    logic [5:0] funct6;
    logic [2:0] funct3;
    logic       vx_form;
    logic       op_ok;
    rvv_uop_t   dec;

    assign funct6  = cq_data.inst[31:26];
    assign funct3  = cq_data.inst[14:12];
    assign vx_form = (funct3 == f3_opivx);

    // Refill only when the output register is free or handing over
    assign cq_pop = !cq_empty && (!uop_valid || uop_ready);

    always_comb begin
        dec        = '0;
        op_ok      = 1'b1;
        // Only eight registers, keep the low index bits
        dec.vd     = cq_data.inst[9:7];
        dec.vs1    = cq_data.inst[17:15];
        dec.vs2    = cq_data.inst[22:20];
        dec.sew    = cq_data.sew;
        dec.scalar = cq_data.rs1_data;
        case (funct6)
            f6_add:  dec.op = op_add;
            f6_sub:  dec.op = op_sub;
            f6_and:  dec.op = op_and;
            f6_or:   dec.op = op_or;
            f6_xor:  dec.op = op_xor;
            f6_move: dec.op = op_move;
            default: op_ok = 1'b0;
        endcase
        if (funct3 != f3_opivv && !vx_form) begin
            op_ok = 1'b0;
        end
        // vmv.v.v is not supported, only the scalar broadcast
        if (dec.op == op_move && !vx_form) begin
            op_ok = 1'b0;
        end
        dec.illegal  = !op_ok || (cq_data.sew == sew_64);
        dec.vs1_used = !dec.illegal && !vx_form;
        dec.vs2_used = !dec.illegal && (dec.op != op_move);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop_valid <= 1'b0;
            uop       <= '0;
        end else if (!uop_valid || uop_ready) begin
            uop_valid <= cq_pop;
            if (cq_pop) begin
                uop <= dec;
            end
        end
    end

endmodule

`default_nettype wire

//--- rvv_dispatch.sv
`default_nettype none

module rvv_dispatch (
    input  logic                                uop_valid,
    input  rvv_pkg::rvv_uop_t                   uop,
    output logic                                uop_ready,
    input  logic [rvv_pkg::num_vreg-1:0]        pending_vregs,
    output rvv_pkg::vreg_idx_t [1:0]            rd_idx,
    input  logic [1:0][rvv_pkg::vlen-1:0]       rd_data,
    output logic                                alloc_valid,
    output rvv_pkg::rob_alloc_t                 alloc,
    input  logic                                alloc_ready,
    input  rvv_pkg::rob_idx_t                   alloc_idx,
    output logic                                rs_push,
    output rvv_pkg::alu_uop_t                   rs_data,
    input  logic                                rs_ready
);

    import rvv_pkg::*;

    logic hazard;
    logic path_clear;

    // RAW check against destinations still waiting to retire
    assign hazard = (uop.vs1_used && pending_vregs[uop.vs1])
                 || (uop.vs2_used && pending_vregs[uop.vs2]);

    // Illegal uops need only a reorder slot
    assign path_clear = !hazard && (uop.illegal || rs_ready);

    assign uop_ready   = alloc_ready && path_clear;
    assign alloc_valid = uop_valid && path_clear;
    assign rs_push     = uop_valid && !hazard && !uop.illegal && alloc_ready && rs_ready;

    assign rd_idx[0] = uop.vs1;
    assign rd_idx[1] = uop.vs2;

    assign alloc.vd      = uop.vd;
    assign alloc.done    = uop.illegal;
    assign alloc.illegal = uop.illegal;

    always_comb begin
        rs_data.op       = uop.op;
        rs_data.sew      = uop.sew;
        rs_data.vs2_data = rd_data[1];
        rs_data.rob_idx  = alloc_idx;
        // The source a form does not use goes out as zero
        if (uop.vs1_used) begin
            rs_data.vs1_data = rd_data[0];
            rs_data.scalar   = '0;
        end else begin
            rs_data.vs1_data = '0;
            rs_data.scalar   = uop.scalar;
        end
    end

endmodule

`default_nettype wire

//--- rvv_fifo.sv
`default_nettype none

module rvv_fifo #(
    parameter type T        = logic [7:0],
    parameter int  depth    = 8,
    parameter int  num_push = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [num_push-1:0] push,
    input  T     [num_push-1:0] push_data,
    input  logic                pop,
    output T                    pop_data,
    output logic                empty,
    output logic [num_push-1:0] free_ok
);

    // Depth is a power of two, so pointers wrap on their own
    typedef logic [$clog2(depth)-1:0]   ptr_t;
    typedef logic [$clog2(depth+1)-1:0] cnt_t;

    T mem [depth];

    ptr_t                rd_ptr;
    ptr_t                wr_ptr;
    cnt_t                count;
    cnt_t                count_next;
    cnt_t                num_in;
    ptr_t [num_push-1:0] wr_addr;

    // Pushes land at consecutive slots in port order
    always_comb begin
        num_in = '0;
        for (int k = 0; k < num_push; k++) begin
            wr_addr[k] = wr_ptr + ptr_t'(num_in);
            num_in     = num_in + cnt_t'(push[k]);
        end
        count_next = count + num_in - cnt_t'(pop);
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < num_push; k++) begin
            if (push[k]) begin
                mem[wr_addr[k]] <= push_data[k];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count   <= '0;
            empty   <= 1'b1;
            free_ok <= '1;
        end else begin
            wr_ptr <= wr_ptr + ptr_t'(num_in);
            if (pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            count <= count_next;
            empty <= (count_next == '0);
            // Bit k set while k+1 slots remain
            for (int k = 0; k < num_push; k++) begin
                free_ok[k] <= (int'(count_next) + k < depth);
            end
        end
    end

    assign pop_data = mem[rd_ptr];

endmodule

`default_nettype wire

//--- rvv_pkg.sv
`default_nettype none

package rvv_pkg;

    // Sizes
    localparam int issue_lanes = 2;
    localparam int vlen        = 64;
    localparam int num_vreg    = 8;
    localparam int cq_depth    = 8;
    localparam int rs_depth    = 4;
    localparam int rob_depth   = 8;

    typedef logic [2:0] vreg_idx_t;
    typedef logic [2:0] rob_idx_t;
    typedef logic [1:0] vsew_t;

    // Element width codes, 64 bits is not supported
    localparam vsew_t sew_8  = 2'd0;
    localparam vsew_t sew_16 = 2'd1;
    localparam vsew_t sew_32 = 2'd2;
    localparam vsew_t sew_64 = 2'd3;

    // OPIVV / OPIVX funct6 codes
    localparam logic [5:0] f6_add  = 6'b000000;
    localparam logic [5:0] f6_sub  = 6'b000010;
    localparam logic [5:0] f6_and  = 6'b001001;
    localparam logic [5:0] f6_or   = 6'b001010;
    localparam logic [5:0] f6_xor  = 6'b001011;
    localparam logic [5:0] f6_move = 6'b010111;

    localparam logic [2:0] f3_opivv = 3'b000;
    localparam logic [2:0] f3_opivx = 3'b100;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_move
    } alu_op_e;

    typedef struct packed {
        logic [31:0] inst;
        vsew_t       sew;
        logic [31:0] rs1_data;
    } rvv_cmd_t;

    typedef struct packed {
        alu_op_e     op;
        vreg_idx_t   vd;
        vreg_idx_t   vs1;
        vreg_idx_t   vs2;
        vsew_t       sew;
        logic [31:0] scalar;
        logic        vs1_used;
        logic        vs2_used;
        logic        illegal;
    } rvv_uop_t;

    typedef struct packed {
        alu_op_e         op;
        vsew_t           sew;
        logic [vlen-1:0] vs1_data;
        logic [vlen-1:0] vs2_data;
        logic [31:0]     scalar;
        rob_idx_t        rob_idx;
    } alu_uop_t;

    typedef struct packed {
        vreg_idx_t vd;
        logic      done;
        logic      illegal;
    } rob_alloc_t;

    typedef struct packed {
        rob_idx_t        rob_idx;
        logic [vlen-1:0] data;
    } rob_wb_t;

    typedef struct packed {
        vreg_idx_t       vd;
        logic            illegal;
        logic [vlen-1:0] data;
    } retire_t;

    typedef struct packed {
        vreg_idx_t       idx;
        logic [vlen-1:0] data;
    } vrf_wr_t;

endpackage

`default_nettype wire

//--- rvv_rob.sv
`default_nettype none

module rvv_rob (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         alloc_valid,
    input  rvv_pkg::rob_alloc_t          alloc,
    output logic                         alloc_ready,
    output rvv_pkg::rob_idx_t            alloc_idx,
    input  logic                         wb_valid,
    input  rvv_pkg::rob_wb_t             wb,
    output logic [rvv_pkg::num_vreg-1:0] pending_vregs,
    output logic                         rt_valid,
    output rvv_pkg::retire_t             rt,
    input  logic                         rt_ready,
    output logic                         vrf_wr_valid,
    output rvv_pkg::vrf_wr_t             vrf_wr
);

    import rvv_pkg::*;

    typedef logic [$clog2(rob_depth+1)-1:0] cnt_t;

    logic [rob_depth-1:0] ent_valid;
    logic [rob_depth-1:0] ent_done;
    logic [rob_depth-1:0] ent_illegal;
    vreg_idx_t            ent_vd [rob_depth];
    logic [vlen-1:0]      ent_data [rob_depth];

    rob_idx_t head;
    rob_idx_t tail;
    cnt_t     count;
    logic     do_alloc;
    logic     do_retire;

    assign alloc_ready = (int'(count) != rob_depth);
    assign alloc_idx   = tail;
    assign do_alloc    = alloc_valid && alloc_ready;

    assign rt_valid  = ent_valid[head] && ent_done[head];
    assign do_retire = rt_valid && rt_ready;

    // Illegal entries never saw a writeback
    assign rt.vd      = ent_vd[head];
    assign rt.illegal = ent_illegal[head];
    assign rt.data    = ent_illegal[head] ? '0 : ent_data[head];

    assign vrf_wr_valid = do_retire && !ent_illegal[head];
    assign vrf_wr.idx   = ent_vd[head];
    assign vrf_wr.data  = ent_data[head];

    // Rebuilt from live entries so a repeated vd stays pending
    always_comb begin
        pending_vregs = '0;
        for (int i = 0; i < rob_depth; i++) begin
            if (ent_valid[i] && !ent_illegal[i]) begin
                pending_vregs[ent_vd[i]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            ent_vd[tail] <= alloc.vd;
        end
        if (wb_valid) begin
            ent_data[wb.rob_idx] <= wb.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            ent_valid   <= '0;
            ent_done    <= '0;
            ent_illegal <= '0;
        end else begin
            if (do_alloc) begin
                ent_valid[tail]   <= 1'b1;
                ent_done[tail]    <= alloc.done;
                ent_illegal[tail] <= alloc.illegal;
                tail              <= tail + rob_idx_t'(1);
            end
            if (wb_valid) begin
                ent_done[wb.rob_idx] <= 1'b1;
            end
            if (do_retire) begin
                ent_valid[head] <= 1'b0;
                head            <= head + rob_idx_t'(1);
            end
            count <= count + cnt_t'(do_alloc) - cnt_t'(do_retire);
        end
    end

endmodule

`default_nettype wire

//--- rvv_vrf.sv
`default_nettype none

module rvv_vrf (
    input  logic                          clk,
    input  logic                          rst_n,
    input  rvv_pkg::vreg_idx_t [1:0]      rd_idx,
    output logic [1:0][rvv_pkg::vlen-1:0] rd_data,
    input  logic                          wr_valid,
    input  rvv_pkg::vrf_wr_t              wr
);

    import rvv_pkg::*;

    logic [vlen-1:0] regs [num_vreg];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_vreg; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            regs[wr.idx] <= wr.data;
        end
    end

    // Both read ports are combinational
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            rd_data[k] = regs[rd_idx[k]];
        end
    end

endmodule

`default_nettype wire

//--- tb_rvv_backend.sv
`default_nettype none

module tb_rvv_backend;

    timeunit 1ns;
    timeprecision 100ps;

    import rvv_pkg::*;

    typedef enum logic [1:0] {
        ready_high,
        ready_random,
        ready_low
    } ready_mode_e;

    // About 60 instructions, each well under 30 cycles even with back-pressure
    localparam int max_cycles = 2000;

    logic                  clk;
    logic                  rst_n;
    logic [1:0]            inst_valid;
    rvv_cmd_t [1:0]        inst;
    logic [1:0]            inst_ready;
    logic                  rt_valid;
    retire_t               rt;
    logic                  rt_ready;

    rvv_cmd_t              issue_q [$];
    retire_t               expect_q [$];
    logic [vlen-1:0]       model_vreg [num_vreg];
    logic [1:0]            lane_ready;
    ready_mode_e           ready_mode;
    retire_t               exp_rt;
    integer                seed;
    int                    rnd;
    int                    errors;
    int                    cycles;
    int                    accepted;
    int                    retired;
    int                    dual_count;
    int                    illegal_seen;

    rvv_backend dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .rt_valid   (rt_valid),
        .rt         (rt),
        .rt_ready   (rt_ready)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0d ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic report_and_finish();
        $display("Run finished: %0d errors, %0d accepted, %0d retired", errors, accepted,
                 retired);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    function automatic rvv_cmd_t make_cmd(input logic [5:0] f6, input logic [2:0] f3,
                                          input int vd, input int vs2, input int vs1,
                                          input vsew_t sew, input logic [31:0] scalar);
        rvv_cmd_t c;
        c.inst     = {f6, 1'b1, 5'(vs2), 5'(vs1), f3, 5'(vd), 7'b1010111};
        c.sew      = sew;
        c.rs1_data = scalar;
        return c;
    endfunction

    // Predicts the retire of one accepted instruction and updates the register model
    task automatic predict(input rvv_cmd_t c);
        logic [5:0]  f6;
        logic [2:0]  f3;
        logic [2:0]  vd;
        logic [2:0]  vs1;
        logic [2:0]  vs2;
        logic        vx;
        logic        ok;
        int          w;
        logic [63:0] mask;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] er;
        logic [63:0] r;
        retire_t     e;
        f6  = c.inst[31:26];
        f3  = c.inst[14:12];
        vd  = c.inst[9:7];
        vs1 = c.inst[17:15];
        vs2 = c.inst[22:20];
        vx  = (f3 == f3_opivx);
        ok  = (f3 == f3_opivv || vx) && (c.sew != sew_64);
        ok  = ok && (f6 == f6_add || f6 == f6_sub || f6 == f6_and || f6 == f6_or
                     || f6 == f6_xor || (f6 == f6_move && vx));
        e.vd      = vd;
        e.illegal = !ok;
        e.data    = '0;
        if (ok) begin
            w    = 8 << int'(c.sew);
            mask = (64'd1 << w) - 64'd1;
            r    = '0;
            for (int i = 0; i < vlen / w; i++) begin
                eb = (model_vreg[vs2] >> (i * w)) & mask;
                ea = vx ? (64'(c.rs1_data) & mask) : ((model_vreg[vs1] >> (i * w)) & mask);
                case (f6)
                    f6_add:  er = eb + ea;
                    f6_sub:  er = eb - ea;
                    f6_and:  er = eb & ea;
                    f6_or:   er = eb | ea;
                    f6_xor:  er = eb ^ ea;
                    default: er = ea;
                endcase
                r = r | ((er & mask) << (i * w));
            end
            e.data          = r;
            model_vreg[vd] = r;
        end
        expect_q.push_back(e);
        accepted++;
    endtask

    // Oldest queued instruction goes on lane 0 and the next one on lane 1
    always @(posedge clk) begin
        #1;
        if (inst_valid[0] && lane_ready[0]) begin
            predict(issue_q.pop_front());
            if (inst_valid[1] && lane_ready[1]) begin
                predict(issue_q.pop_front());
                dual_count++;
            end
        end
        inst_valid[0] = (issue_q.size() > 0);
        inst_valid[1] = (issue_q.size() > 1);
        inst[0]       = (issue_q.size() > 0) ? issue_q[0] : '0;
        inst[1]       = (issue_q.size() > 1) ? issue_q[1] : '0;
        lane_ready    = inst_ready;
    end

    always @(posedge clk) begin
        #1;
        case (ready_mode)
            ready_high: rt_ready = 1'b1;
            ready_random: begin
                rnd      = $random(seed);
                rt_ready = (rnd[1:0] != 2'b00);
            end
            default: rt_ready = 1'b0;
        endcase
    end

    // Retire outputs and rt_ready are both stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && rt_valid && rt_ready) begin
            retired++;
            if (rt.illegal) begin
                illegal_seen++;
            end
            if (expect_q.size() == 0) begin
                errors++;
                $display("Unexpected retire at %0d ns with no instruction outstanding", $time);
            end else begin
                exp_rt = expect_q.pop_front();
                check_value("rt.vd", 64'(rt.vd), 64'(exp_rt.vd));
                check_value("rt.illegal", 64'(rt.illegal), 64'(exp_rt.illegal));
                check_value("rt.data", rt.data, exp_rt.data);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == max_cycles) begin
            errors++;
            $display("Timeout after %0d cycles with %0d instructions still expected", cycles,
                     expect_q.size());
            report_and_finish();
        end
    end

    task automatic wait_drain();
        while (issue_q.size() != 0 || expect_q.size() != 0 || inst_valid != 2'b00) begin
            @(negedge clk);
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_value("inst_ready", 64'(inst_ready), 64'(2'b11));
        check_value("rt_valid", 64'(rt_valid), 64'(1'b0));
        issue_q.push_back(make_cmd(f6_add, f3_opivv, 1, 2, 3, sew_8, 32'h0));
        wait_drain();
    endtask

    task automatic test_move_add();
        issue_q.push_back(make_cmd(f6_move, f3_opivx, 1, 0, 0, sew_8, 32'h0000_00f0));
        issue_q.push_back(make_cmd(f6_move, f3_opivx, 2, 0, 0, sew_8, 32'h0000_0025));
        issue_q.push_back(make_cmd(f6_add, f3_opivv, 5, 1, 2, sew_8, 32'h0));
        // Upper scalar bits drop at element width 8
        issue_q.push_back(make_cmd(f6_move, f3_opivx, 3, 0, 0, sew_8, 32'h1234_5681));
        issue_q.push_back(make_cmd(f6_add, f3_opivv, 6, 3, 1, sew_8, 32'h0));
        wait_drain();
    endtask

    task automatic test_widths_forms();
        logic [5:0] ops [4];
        vsew_t      sews [2];
        ops[0]  = f6_sub;
        ops[1]  = f6_and;
        ops[2]  = f6_or;
        ops[3]  = f6_xor;
        sews[0] = sew_16;
        sews[1] = sew_32;
        issue_q.push_back(make_cmd(f6_move, f3_opivx, 1, 0, 0, sew_16, 32'habcd_1234));
        issue_q.push_back(make_cmd(f6_move, f3_opivx, 2, 0, 0, sew_32, 32'h8000_0001));
        for (int o = 0; o < 4; o++) begin
            for (int s = 0; s < 2; s++) begin
                issue_q.push_back(make_cmd(ops[o], f3_opivv, 3, 1, 2, sews[s], 32'h0));
                issue_q.push_back(make_cmd(ops[o], f3_opivx, 4, 2, 0, sews[s],
                                           32'hffff_0005));
            end
        end
        wait_drain();
    endtask

    task automatic test_dependency_chain();
        int src;
        int dst;
        int dual_before;
        dual_before = dual_count;
        for (int k = 0; k < 8; k++) begin
            src = (k + 1) % num_vreg;
            dst = (k + 2) % num_vreg;
            if (k % 2 == 0) begin
                issue_q.push_back(make_cmd(f6_add, f3_opivx, dst, src, 0, sew_32,
                                           32'h0101_0101 * (k + 1)));
            end else begin
                issue_q.push_back(make_cmd(f6_add, f3_opivv, dst, src, src, sew_16, 32'h0));
            end
        end
        wait_drain();
        if (dual_count == dual_before) begin
            errors++;
            $display("Dependency chain was never accepted on both lanes in one cycle");
        end
    endtask

    task automatic test_backpressure();
        int waited;
        ready_mode = ready_low;
        @(negedge clk);
        // Every later instruction reads v7, so dispatch stalls behind the first
        issue_q.push_back(make_cmd(f6_move, f3_opivx, 7, 0, 0, sew_8, 32'h0000_0011));
        for (int k = 1; k < 16; k++) begin
            issue_q.push_back(make_cmd(f6_add, f3_opivx, k % 7, 7, 0, sew_8, 32'(k)));
        end
        waited = 0;
        while (inst_ready[0] && waited < 64) begin
            @(negedge clk);
            waited++;
        end
        if (inst_ready[0]) begin
            errors++;
            $display("inst_ready stayed high while retirement was blocked");
        end
        if (issue_q.size() == 0) begin
            errors++;
            $display("All 16 instructions were accepted while retirement was blocked");
        end
        ready_mode = ready_random;
        wait_drain();
    endtask

    task automatic test_illegal();
        int illegal_before;
        illegal_before = illegal_seen;
        issue_q.push_back(make_cmd(f6_move, f3_opivx, 2, 0, 0, sew_8, 32'h0000_005a));
        issue_q.push_back(make_cmd(f6_move, f3_opivx, 3, 0, 0, sew_8, 32'h0000_003c));
        issue_q.push_back(make_cmd(6'b111111, f3_opivv, 2, 1, 1, sew_8, 32'h0));
        issue_q.push_back(make_cmd(f6_add, f3_opivv, 3, 1, 1, sew_64, 32'h0));
        issue_q.push_back(make_cmd(f6_add, f3_opivx, 4, 2, 0, sew_8, 32'h0));
        issue_q.push_back(make_cmd(f6_or, f3_opivv, 5, 3, 3, sew_8, 32'h0));
        wait_drain();
        check_value("illegal retires", 64'(illegal_seen - illegal_before), 64'd2);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst_valid   = '0;
        inst         = '0;
        rt_ready     = 1'b0;
        lane_ready   = '0;
        ready_mode   = ready_high;
        seed         = 32'hdbb0_dc55;
        errors       = 0;
        cycles       = 0;
        accepted     = 0;
        retired      = 0;
        dual_count   = 0;
        illegal_seen = 0;
        for (int i = 0; i < num_vreg; i++) begin
            model_vreg[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_state();
        ready_mode = ready_random;
        test_move_add();
        test_widths_forms();
        test_dependency_chain();
        test_backpressure();
        test_illegal();
        // Backend stays idle once every accepted instruction has retired
        repeat (8) @(negedge clk);
        check_value("rt_valid", 64'(rt_valid), 64'(1'b0));
        report_and_finish();
    end

endmodule

`default_nettype wire
